/* vlog.f */
+incdir+logic
+incdir+verification
logic/soc_pkg.sv
logic/soc_router.sv
logic/soc_l2_mem.sv
logic/soc_ctrl_regs.sv
logic/soc_apb_bridge.sv
logic/soc_top.sv
verification/tb_clkgen.sv
verification/tb_soc_top.sv

/* Bender.yml */
package:
  name: soc_fabric

sources:
  - include_dirs:
      - logic
    files:
      - logic/soc_pkg.sv
      - logic/soc_router.sv
      - logic/soc_l2_mem.sv
      - logic/soc_ctrl_regs.sv
      - logic/soc_apb_bridge.sv
      - logic/soc_top.sv

  - target: test
    include_dirs:
      - logic
      - verification
    files:
      - verification/tb_clkgen.sv
      - verification/tb_soc_top.sv

/* verification/tb_soc_tasks.svh */
// Bus helpers assume one outstanding request and sample DUT outputs only on falling edges
`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

localparam int          timeout_cycles = 100;
localparam logic [31:0] addr_exit      = `SOC_CTRL_BASE + `SOC_REG_EXIT;
localparam logic [31:0] addr_cnt_en    = `SOC_CTRL_BASE + `SOC_REG_CNT_EN;
localparam logic [31:0] addr_l2_base   = `SOC_CTRL_BASE + `SOC_REG_L2_BASE;
localparam logic [31:0] addr_l2_end    = `SOC_CTRL_BASE + `SOC_REG_L2_END;

soc_pkg::soc_data_t l2_model [`SOC_L2_WORDS] = '{default: '0};
logic [31:0]        uart_mirror [16] = '{default: '0};

//////////////////////////////////////////////////////////////////////
// Failure reporting and compares

task automatic abort_run();
  $display("Test FAILED");
  $fatal(1, "Simulation stopped after an error");
endtask

task automatic report_timeout(input string what);
  $display("Timeout after %0d cycles waiting for %s", timeout_cycles, what);
  abort_run();
endtask

task automatic check_rsp(input soc_pkg::soc_rsp_t got, input soc_pkg::soc_rsp_t exp,
                         input string what);
  if (got !== exp) begin
    $display("[ERROR] %0t %s: rdata %h err %b, expected rdata %h err %b",
             $time, what, got.rdata, got.err, exp.rdata, exp.err);
    abort_run();
  end
endtask

task automatic check_word(input soc_pkg::soc_data_t got, input soc_pkg::soc_data_t exp,
                          input string what);
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
    abort_run();
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
    abort_run();
  end
endtask

task automatic check_apb_write(input logic [31:0] exp_addr, input logic [31:0] exp_data,
                               input string what);
  if (last_paddr !== exp_addr || last_pwdata !== exp_data) begin
    $display("[ERROR] %0t %s: paddr %h pwdata %h, expected paddr %h pwdata %h",
             $time, what, last_paddr, last_pwdata, exp_addr, exp_data);
    abort_run();
  end
endtask

function automatic soc_pkg::soc_data_t merge_bytes(input soc_pkg::soc_data_t old_d,
                                                   input soc_pkg::soc_data_t new_d,
                                                   input soc_pkg::soc_strb_t strb);
  soc_pkg::soc_data_t mask;
  for (int b = 0; b < 8; b++) begin
    mask[8*b +: 8] = {8{strb[b]}};
  end
  return (old_d & ~mask) | (new_d & mask);
endfunction

//////////////////////////////////////////////////////////////////////
// Bus driver

task automatic send_req(input soc_pkg::soc_req_t q, input logic ready);
  int n;
  @(negedge clk);
  req_valid = 1'b1;
  req       = q;
  rsp_ready = ready;
  n = 0;
  while (!req_ready) begin
    n = n + 1;
    if (n > timeout_cycles) report_timeout("request acceptance");
    @(negedge clk);
  end
  // Accepted on the next rising edge
  @(negedge clk);
  req_valid = 1'b0;
endtask

task automatic wait_rsp(output soc_pkg::soc_rsp_t r);
  int n;
  n = 0;
  while (!rsp_valid) begin
    n = n + 1;
    if (n > timeout_cycles) report_timeout("a response");
    @(negedge clk);
  end
  r = rsp;
endtask

task automatic bus_xfer(input logic we, input logic [31:0] addr, input soc_pkg::soc_data_t wdata,
                        input soc_pkg::soc_strb_t strb, output soc_pkg::soc_rsp_t r);
  soc_pkg::soc_req_t q;
  q.we    = we;
  q.addr  = addr;
  q.wdata = wdata;
  q.strb  = strb;
  send_req(q, 1'b1);
  wait_rsp(r);
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests

task automatic test_reset();
  int n;
  n = 0;
  while (arst_n !== 1'b1) begin
    n = n + 1;
    if (n > timeout_cycles) report_timeout("reset release");
    @(negedge clk);
  end
  @(negedge clk);
  check_word(exit_val, '0, "exit_o after reset");
  check_word(cnt_en_val, '0, "hw_cnt_en_o after reset");
  check_flag(rsp_valid, 1'b0, "rsp_valid_o after reset");
  check_flag(req_ready, 1'b1, "req_ready_o after reset");
  check_flag(apb_req.psel, 1'b0, "psel after reset");
  check_flag(apb_req.penable, 1'b0, "penable after reset");
endtask

task automatic test_l2();
  int unsigned        idx [12];
  soc_pkg::soc_data_t wd;
  soc_pkg::soc_strb_t st;
  soc_pkg::soc_rsp_t  r;
  for (int i = 0; i < 12; i++) begin
    // Every third write lands on the word before it
    idx[i] = (i % 3 == 2) ? idx[i-1] : $unsigned($random(seed)) % `SOC_L2_WORDS;
    wd     = {$random(seed), $random(seed)};
    st     = (i < 4) ? 8'hFF : 8'($random(seed));
    bus_xfer(1'b1, `SOC_L2_BASE + idx[i] * 8, wd, st, r);
    check_flag(r.err, 1'b0, "L2 write err");
    l2_model[idx[i]] = merge_bytes(l2_model[idx[i]], wd, st);
  end
  for (int i = 0; i < 12; i++) begin
    bus_xfer(1'b0, `SOC_L2_BASE + idx[i] * 8, '0, '0, r);
    check_rsp(r, soc_pkg::soc_rsp_t'{rdata: l2_model[idx[i]], err: 1'b0}, "L2 read back");
  end
endtask

task automatic test_ctrl();
  soc_pkg::soc_data_t exp_exit;
  soc_pkg::soc_data_t exp_cnt;
  soc_pkg::soc_data_t wd;
  soc_pkg::soc_rsp_t  r;
  wd       = {$random(seed), $random(seed)};
  exp_exit = wd;
  bus_xfer(1'b1, addr_exit, wd, 8'hFF, r);
  check_flag(r.err, 1'b0, "exit write err");
  check_word(exit_val, exp_exit, "exit_o after full write");
  wd       = {$random(seed), $random(seed)};
  exp_exit = merge_bytes(exp_exit, wd, 8'h0F);
  bus_xfer(1'b1, addr_exit, wd, 8'h0F, r);
  check_word(exit_val, exp_exit, "exit_o after partial write");
  wd      = {$random(seed), $random(seed)};
  exp_cnt = merge_bytes('0, wd, 8'hA5);
  bus_xfer(1'b1, addr_cnt_en, wd, 8'hA5, r);
  check_flag(r.err, 1'b0, "counter enable write err");
  check_word(cnt_en_val, exp_cnt, "hw_cnt_en_o after partial write");
  bus_xfer(1'b0, addr_exit, '0, '0, r);
  check_rsp(r, soc_pkg::soc_rsp_t'{rdata: exp_exit, err: 1'b0}, "exit read back");
  bus_xfer(1'b0, addr_cnt_en, '0, '0, r);
  check_rsp(r, soc_pkg::soc_rsp_t'{rdata: exp_cnt, err: 1'b0}, "counter enable read back");
  bus_xfer(1'b0, addr_l2_base, '0, '0, r);
  check_rsp(r, soc_pkg::soc_rsp_t'{rdata: 64'(`SOC_L2_BASE), err: 1'b0}, "L2 base read");
  bus_xfer(1'b0, addr_l2_end, '0, '0, r);
  check_rsp(r, soc_pkg::soc_rsp_t'{rdata: 64'(`SOC_L2_BASE + `SOC_L2_LEN), err: 1'b0},
            "L2 end read");
  // Rejected write to a read-only register
  bus_xfer(1'b1, addr_l2_base, '1, 8'hFF, r);
  check_flag(r.err, 1'b1, "write to L2 base err");
  bus_xfer(1'b0, addr_l2_base, '0, '0, r);
  check_rsp(r, soc_pkg::soc_rsp_t'{rdata: 64'(`SOC_L2_BASE), err: 1'b0}, "L2 base after write");
  check_word(exit_val, exp_exit, "exit_o after rejected write");
  check_word(cnt_en_val, exp_cnt, "hw_cnt_en_o after rejected write");
endtask

task automatic test_uart();
  int unsigned        ri;
  logic [31:0]        a;
  logic [31:0]        wr_addr;
  logic [31:0]        wr_data;
  soc_pkg::soc_data_t wd;
  soc_pkg::soc_rsp_t  r;
  for (int i = 0; i < 6; i++) begin
    ri = $unsigned($random(seed)) % 8;
    a  = `SOC_UART_BASE + ri * 8;
    wd = {$random(seed), $random(seed)};
    bus_xfer(1'b1, a, wd, 8'hFF, r);
    check_flag(r.err, 1'b0, "UART write err");
    check_apb_write(a, wd[31:0], "UART write on APB");
    uart_mirror[a[5:2]] = wd[31:0];
    wr_addr = a;
    wr_data = wd[31:0];
  end
  for (int i = 0; i < 8; i++) begin
    a = `SOC_UART_BASE + i * 8;
    bus_xfer(1'b0, a, '0, '0, r);
    check_rsp(r, soc_pkg::soc_rsp_t'{rdata: {32'h0, uart_mirror[a[5:2]]}, err: 1'b0},
              "UART read");
    // A read must not show up as an APB write
    check_apb_write(wr_addr, wr_data, "APB write during UART read");
  end
endtask

task automatic test_errors();
  int                 cnt0;
  soc_pkg::soc_data_t wd;
  soc_pkg::soc_rsp_t  r;
  wd = {$random(seed), $random(seed)};
  bus_xfer(1'b1, `SOC_L2_BASE + 32'h40, wd, 8'hFF, r);
  l2_model[8] = wd;
  cnt0 = apb_xfer_cnt;
  bus_xfer(1'b1, 32'h1000_0000, ~wd, 8'hFF, r);
  check_flag(r.err, 1'b1, "unmapped write err");
  bus_xfer(1'b0, `SOC_L2_BASE + `SOC_L2_LEN, '0, '0, r);
  check_flag(r.err, 1'b1, "read past L2 end err");
  bus_xfer(1'b1, `SOC_L2_BASE + 32'h44, ~wd, 8'hFF, r);
  check_flag(r.err, 1'b1, "misaligned L2 write err");
  bus_xfer(1'b1, `SOC_UART_BASE + 32'h2, ~wd, 8'hFF, r);
  check_flag(r.err, 1'b1, "misaligned UART write err");
  bus_xfer(1'b0, `SOC_UART_BASE + `SOC_UART_LEN, '0, '0, r);
  check_flag(r.err, 1'b1, "read past UART page err");
  if (apb_xfer_cnt != cnt0) begin
    $display("An APB transfer was started by a request that should have failed");
    abort_run();
  end
  bus_xfer(1'b0, `SOC_L2_BASE + 32'h40, '0, '0, r);
  check_rsp(r, soc_pkg::soc_rsp_t'{rdata: l2_model[8], err: 1'b0}, "L2 word after errors");
endtask

task automatic test_backpressure();
  int                hold;
  soc_pkg::soc_req_t q;
  soc_pkg::soc_rsp_t held;
  q      = '0;
  q.addr = `SOC_L2_BASE + 32'h40;
  send_req(q, 1'b0);
  wait_rsp(held);
  check_rsp(held, soc_pkg::soc_rsp_t'{rdata: l2_model[8], err: 1'b0}, "held response");
  hold = 1 + $unsigned($random(seed)) % 6;
  for (int i = 0; i < hold; i++) begin
    @(negedge clk);
    check_rsp(rsp, held, "rsp_o under back-pressure");
    check_flag(rsp_valid, 1'b1, "rsp_valid_o under back-pressure");
    check_flag(req_ready, 1'b0, "req_ready_o under back-pressure");
  end
  rsp_ready = 1'b1;
  @(negedge clk);
  check_flag(req_ready, 1'b1, "req_ready_o after response transfer");
endtask

`endif

/* verification/tb_soc_top.sv */
// Directed tests; one request at a time, APB slave always answers OKAY after 0 to 3 wait states
`include "soc_params.svh"

module tb_soc_top;

  logic               clk;
  logic               arst_n;
  logic               req_valid;
  soc_pkg::soc_req_t  req;
  logic               req_ready;
  logic               rsp_valid;
  soc_pkg::soc_rsp_t  rsp;
  logic               rsp_ready;
  soc_pkg::apb_req_t  apb_req;
  soc_pkg::apb_rsp_t  apb_rsp;
  soc_pkg::soc_data_t exit_val;
  soc_pkg::soc_data_t cnt_en_val;

  int          seed = 84;
  logic [31:0] apb_regs [16];
  logic [31:0] last_paddr;
  logic [31:0] last_pwdata;
  int          apb_xfer_cnt;
  int          wait_cnt;

  tb_clkgen i_clkgen (
    .clk_o   (clk   ),
    .arst_n_o(arst_n)
  );

  soc_top dut (
    .clk_i         (clk       ),
    .arst_n_i      (arst_n    ),
    .req_valid_i   (req_valid ),
    .req_i         (req       ),
    .req_ready_o   (req_ready ),
    .rsp_valid_o   (rsp_valid ),
    .rsp_o         (rsp       ),
    .rsp_ready_i   (rsp_ready ),
    .uart_apb_req_o(apb_req   ),
    .uart_apb_rsp_i(apb_rsp   ),
    .exit_o        (exit_val  ),
    .hw_cnt_en_o   (cnt_en_val)
  );

  //////////////////////////////////////////////////////////////////////
  // APB slave model

  initial begin
    for (int i = 0; i < 16; i++) begin
      apb_regs[i] = '0;
    end
    apb_xfer_cnt = 0;
    last_paddr   = '0;
    last_pwdata  = '0;
    wait_cnt     = 0;
  end

  // Wait states drawn in the setup cycle
  always @(negedge clk) begin
    if (arst_n) begin
      if (!apb_req.psel || !apb_req.penable) begin
        apb_rsp.pready = 1'b0;
        if (apb_req.psel) begin
          wait_cnt = $unsigned($random(seed)) % 4;
        end
      end else if (!apb_rsp.pready) begin
        if (wait_cnt == 0) begin
          apb_rsp.pready  = 1'b1;
          apb_rsp.pslverr = 1'b0;
          apb_rsp.prdata  = apb_regs[apb_req.paddr[5:2]];
          apb_xfer_cnt++;
          if (apb_req.pwrite) begin
            apb_regs[apb_req.paddr[5:2]] = apb_req.pwdata;
            last_paddr  = apb_req.paddr;
            last_pwdata = apb_req.pwdata;
          end
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  `include "tb_soc_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    apb_rsp   = '0;
    test_reset();
    test_l2();
    test_ctrl();
    test_uart();
    test_errors();
    test_backpressure();
    $display("Test OK");
    $finish;
  end

endmodule

/* verification/tb_clkgen.sv */
// Free-running clock of 40 time units; reset is held low for the first two cycles
module tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int half_period = 20;

  // Reset released on a falling edge
  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    repeat (2) @(negedge clk_o);
    arst_n_o = 1'b1;
  end

  always #half_period clk_o = ~clk_o;

endmodule

/* logic/soc_top.sv */
// SoC fabric top; one external master, targets fixed by the memory map in soc_params.svh
module soc_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 req_valid_i,
  input  soc_pkg::soc_req_t    req_i,
  output logic                 req_ready_o,
  output logic                 rsp_valid_o,
  output soc_pkg::soc_rsp_t    rsp_o,
  input  logic                 rsp_ready_i,
  output soc_pkg::apb_req_t    uart_apb_req_o,
  input  soc_pkg::apb_rsp_t    uart_apb_rsp_i,
  output soc_pkg::soc_data_t   exit_o,
  output soc_pkg::soc_data_t   hw_cnt_en_o
);

  soc_pkg::soc_tgt_req_t tgt_req;
  logic                  l2_valid, ctrl_valid, uart_valid;
  logic                  l2_done, ctrl_done, uart_done;
  soc_pkg::soc_tgt_rsp_t l2_rsp, ctrl_rsp, uart_rsp;

  //////////////////////////////////////////////////////////////////////
  // Decode stage

  soc_router i_router (
    .clk_i       (clk_i      ),
    .arst_n_i    (arst_n_i   ),
    .req_valid_i (req_valid_i),
    .req_i       (req_i      ),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o      ),
    .rsp_ready_i (rsp_ready_i),
    .tgt_req_o   (tgt_req    ),
    .l2_valid_o  (l2_valid   ),
    .ctrl_valid_o(ctrl_valid ),
    .uart_valid_o(uart_valid ),
    .l2_done_i   (l2_done    ),
    .ctrl_done_i (ctrl_done  ),
    .uart_done_i (uart_done  ),
    .l2_rsp_i    (l2_rsp     ),
    .ctrl_rsp_i  (ctrl_rsp   ),
    .uart_rsp_i  (uart_rsp   )
  );

  //////////////////////////////////////////////////////////////////////
  // Targets

  soc_l2_mem i_l2_mem (
    .clk_i   (clk_i   ),
    .arst_n_i(arst_n_i),
    .valid_i (l2_valid),
    .req_i   (tgt_req ),
    .done_o  (l2_done ),
    .rsp_o   (l2_rsp  )
  );

  soc_ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .valid_i    (ctrl_valid ),
    .req_i      (tgt_req    ),
    .done_o     (ctrl_done  ),
    .rsp_o      (ctrl_rsp   ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

  soc_apb_bridge i_uart_bridge (
    .clk_i    (clk_i         ),
    .arst_n_i (arst_n_i      ),
    .valid_i  (uart_valid    ),
    .req_i    (tgt_req       ),
    .done_o   (uart_done     ),
    .rsp_o    (uart_rsp      ),
    .apb_req_o(uart_apb_req_o),
    .apb_rsp_i(uart_apb_rsp_i)
  );

endmodule

/* logic/soc_apb_bridge.sv */
// APB master for one 32-bit slave; strobes are ignored, only the low data word is transferred
module soc_apb_bridge (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  soc_pkg::soc_tgt_req_t req_i,
  output logic                  done_o,
  output soc_pkg::soc_tgt_rsp_t rsp_o,
  output soc_pkg::apb_req_t     apb_req_o,
  input  soc_pkg::apb_rsp_t     apb_rsp_i
);

  typedef enum logic [1:0] {st_idle, st_setup, st_access} state_e;

  state_e                state_q;
  logic                  done_q;
  logic                  pwrite_q;
  soc_pkg::soc_addr_u    paddr_q;
  logic [31:0]           pwdata_q;
  soc_pkg::soc_tgt_rsp_t rsp_q;
  logic                  xfer_end;

  assign xfer_end = (state_q == st_access) && apb_rsp_i.pready;

  //////////////////////////////////////////////////////////////////////
  // APB sequence

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_idle;
      done_q  <= 1'b0;
    end else begin
      done_q <= xfer_end;
      case (state_q)
        st_idle:   if (valid_i) state_q <= st_setup;
        st_setup:  state_q <= st_access;
        st_access: if (apb_rsp_i.pready) state_q <= st_idle;
        default:   state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && valid_i) begin
      paddr_q  <= req_i.addr;
      pwrite_q <= req_i.we;
      pwdata_q <= req_i.wdata[31:0];
    end
    // Read data zero-extended to the bus word
    if (xfer_end) begin
      rsp_q.rdata <= soc_pkg::soc_data_t'(apb_rsp_i.prdata);
      rsp_q.err   <= apb_rsp_i.pslverr;
    end
  end

  assign apb_req_o.psel    = (state_q != st_idle);
  assign apb_req_o.penable = (state_q == st_access);
  assign apb_req_o.pwrite  = pwrite_q;
  assign apb_req_o.paddr   = paddr_q;
  assign apb_req_o.pwdata  = pwdata_q;

  assign done_o = done_q;
  assign rsp_o  = rsp_q;

  // Access phase always follows a selected setup cycle
  a_penable_psel : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    apb_req_o.penable |-> apb_req_o.psel && $past(apb_req_o.psel));

  // Router never issues while a transfer is open
  a_issue_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i |-> state_q == st_idle);

endmodule

/* logic/soc_ctrl_regs.sv */
// Exit and counter enable are RW with strobes; L2 base/end are RO, writes to them or unknown offsets err
`include "soc_params.svh"

module soc_ctrl_regs (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  soc_pkg::soc_tgt_req_t req_i,
  output logic                  done_o,
  output soc_pkg::soc_tgt_rsp_t rsp_o,
  output soc_pkg::soc_data_t    exit_o,
  output soc_pkg::soc_data_t    hw_cnt_en_o
);

  localparam int unsigned idx_exit    = `SOC_REG_EXIT / (`SOC_DATA_W/8);
  localparam int unsigned idx_cnt_en  = `SOC_REG_CNT_EN / (`SOC_DATA_W/8);
  localparam int unsigned idx_l2_base = `SOC_REG_L2_BASE / (`SOC_DATA_W/8);
  localparam int unsigned idx_l2_end  = `SOC_REG_L2_END / (`SOC_DATA_W/8);

  localparam soc_pkg::soc_data_t l2_base = soc_pkg::soc_data_t'(`SOC_L2_BASE);
  localparam soc_pkg::soc_data_t l2_end  = soc_pkg::soc_data_t'(`SOC_L2_BASE + `SOC_L2_LEN);

  int unsigned           idx;
  soc_pkg::soc_data_t    rd_data;
  logic                  acc_err;
  soc_pkg::soc_data_t    exit_q;
  soc_pkg::soc_data_t    cnt_en_q;
  logic                  done_q;
  soc_pkg::soc_tgt_rsp_t rsp_q;

  assign idx = req_i.addr.regs.index;

  //////////////////////////////////////////////////////////////////////
  // Register decode

  always_comb begin
    rd_data = '0;
    acc_err = 1'b0;
    case (idx)
      idx_exit:   rd_data = exit_q;
      idx_cnt_en: rd_data = cnt_en_q;
      idx_l2_base: begin
        rd_data = l2_base;
        acc_err = req_i.we;
      end
      idx_l2_end: begin
        rd_data = l2_end;
        acc_err = req_i.we;
      end
      default: acc_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= valid_i;
      if (valid_i && req_i.we && !acc_err) begin
        if (idx == idx_exit) begin
          exit_q <= soc_pkg::merge_strb(exit_q, req_i.wdata, req_i.strb);
        end
        if (idx == idx_cnt_en) begin
          cnt_en_q <= soc_pkg::merge_strb(cnt_en_q, req_i.wdata, req_i.strb);
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rsp_q.rdata <= req_i.we ? '0 : rd_data;
      rsp_q.err   <= acc_err;
    end
  end

  assign done_o      = done_q;
  assign rsp_o       = rsp_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

/* logic/soc_l2_mem.sv */
// Single-port L2 with one-cycle read latency; contents start at zero, no reset of the array
`include "soc_params.svh"

module soc_l2_mem (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  soc_pkg::soc_tgt_req_t req_i,
  output logic                  done_o,
  output soc_pkg::soc_tgt_rsp_t rsp_o
);

  localparam soc_pkg::soc_addr_u l2_base = `SOC_L2_BASE;

  soc_pkg::soc_data_t mem_q [`SOC_L2_WORDS] = '{default: '0};
  soc_pkg::soc_data_t rdata_q;
  logic               done_q;

  //////////////////////////////////////////////////////////////////////
  // Storage

  // Byte lanes written separately so the array maps onto byte-enable RAM
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      if (req_i.we) begin
        for (int b = 0; b < `SOC_DATA_W/8; b++) begin
          if (req_i.strb[b]) begin
            mem_q[req_i.addr.mem.word][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      rdata_q <= mem_q[req_i.addr.mem.word];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= valid_i;
    end
  end

  assign done_o      = done_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;

  // Router must only route L2 addresses here
  a_in_region : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i |-> req_i.addr.mem.region == l2_base.mem.region);

endmodule

/* logic/soc_router.sv */
// One request in flight; every target must take its issue pulse at once and answer with one done
`include "soc_params.svh"

module soc_router (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_valid_i,
  input  soc_pkg::soc_req_t     req_i,
  output logic                  req_ready_o,
  output logic                  rsp_valid_o,
  output soc_pkg::soc_rsp_t     rsp_o,
  input  logic                  rsp_ready_i,
  output soc_pkg::soc_tgt_req_t tgt_req_o,
  output logic                  l2_valid_o,
  output logic                  ctrl_valid_o,
  output logic                  uart_valid_o,
  input  logic                  l2_done_i,
  input  logic                  ctrl_done_i,
  input  logic                  uart_done_i,
  input  soc_pkg::soc_tgt_rsp_t l2_rsp_i,
  input  soc_pkg::soc_tgt_rsp_t ctrl_rsp_i,
  input  soc_pkg::soc_tgt_rsp_t uart_rsp_i
);

  typedef enum logic [1:0] {st_idle, st_issue, st_wait, st_resp} state_e;

  state_e                state_q;
  soc_pkg::soc_target_e  tgt_q;
  soc_pkg::soc_target_e  dec_tgt;
  soc_pkg::soc_tgt_req_t req_q;
  soc_pkg::soc_rsp_t     rsp_q;
  logic                  l2_valid_q, ctrl_valid_q, uart_valid_q;
  logic                  sel_done;
  soc_pkg::soc_tgt_rsp_t sel_rsp;

  function automatic logic in_region(logic [`SOC_ADDR_W-1:0] addr,
                                     logic [`SOC_ADDR_W-1:0] base,
                                     logic [`SOC_ADDR_W-1:0] len);
    return (addr >= base) && ((addr - base) < len);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Address decode

  always_comb begin
    dec_tgt = soc_pkg::tgt_none;
    if (req_i.addr.mem.offset == '0) begin
      if (in_region(req_i.addr, `SOC_L2_BASE, `SOC_L2_LEN))
        dec_tgt = soc_pkg::tgt_l2;
      else if (in_region(req_i.addr, `SOC_UART_BASE, `SOC_UART_LEN))
        dec_tgt = soc_pkg::tgt_uart;
      else if (in_region(req_i.addr, `SOC_CTRL_BASE, `SOC_CTRL_LEN))
        dec_tgt = soc_pkg::tgt_ctrl;
    end
  end

  // Unmapped requests finish on their own with an error
  always_comb begin
    case (tgt_q)
      soc_pkg::tgt_l2:   begin sel_done = l2_done_i;   sel_rsp = l2_rsp_i;   end
      soc_pkg::tgt_uart: begin sel_done = uart_done_i; sel_rsp = uart_rsp_i; end
      soc_pkg::tgt_ctrl: begin sel_done = ctrl_done_i; sel_rsp = ctrl_rsp_i; end
      default:           begin sel_done = 1'b1;        sel_rsp = '{rdata: '0, err: 1'b1}; end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= st_idle;
      tgt_q        <= soc_pkg::tgt_none;
      l2_valid_q   <= 1'b0;
      ctrl_valid_q <= 1'b0;
      uart_valid_q <= 1'b0;
    end else begin
      l2_valid_q   <= 1'b0;
      ctrl_valid_q <= 1'b0;
      uart_valid_q <= 1'b0;
      case (state_q)
        st_idle: if (req_valid_i) begin
          tgt_q   <= dec_tgt;
          state_q <= st_issue;
        end
        st_issue: begin
          l2_valid_q   <= (tgt_q == soc_pkg::tgt_l2);
          ctrl_valid_q <= (tgt_q == soc_pkg::tgt_ctrl);
          uart_valid_q <= (tgt_q == soc_pkg::tgt_uart);
          state_q      <= st_wait;
        end
        st_wait: if (sel_done) state_q <= st_resp;
        st_resp: if (rsp_ready_i) state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && req_valid_i) begin
      req_q <= '{we: req_i.we, addr: req_i.addr, wdata: req_i.wdata, strb: req_i.strb};
    end
    if (state_q == st_wait && sel_done) begin
      rsp_q <= '{rdata: sel_rsp.rdata, err: sel_rsp.err};
    end
  end

  assign req_ready_o  = (state_q == st_idle);
  assign rsp_valid_o  = (state_q == st_resp);
  assign rsp_o        = rsp_q;
  assign tgt_req_o    = req_q;
  assign l2_valid_o   = l2_valid_q;
  assign ctrl_valid_o = ctrl_valid_q;
  assign uart_valid_o = uart_valid_q;

  // Held response must not change under back-pressure
  a_rsp_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

/* logic/soc_pkg.sv */
// Single-beat bus types; APB data is fixed at 32 bits, address views assume 8-byte words
`include "soc_params.svh"

package soc_pkg;

  typedef logic [`SOC_DATA_W-1:0]   soc_data_t;
  typedef logic [`SOC_DATA_W/8-1:0] soc_strb_t;

  // L2 view of an address
  typedef struct packed {
    logic [`SOC_ADDR_W-$clog2(`SOC_L2_LEN)-1:0]            region;
    logic [$clog2(`SOC_L2_WORDS)-1:0]                      word;
    logic [$clog2(`SOC_DATA_W/8)-1:0]                      offset;
  } soc_mem_addr_t;

  // Register page view of an address
  typedef struct packed {
    logic [`SOC_ADDR_W-$clog2(`SOC_CTRL_LEN)-1:0]          page;
    logic [$clog2(`SOC_CTRL_LEN)-$clog2(`SOC_DATA_W/8)-1:0] index;
    logic [$clog2(`SOC_DATA_W/8)-1:0]                      offset;
  } soc_reg_addr_t;

  typedef union packed {
    soc_mem_addr_t mem;
    soc_reg_addr_t regs;
  } soc_addr_u;

  typedef struct packed {
    logic      we;
    soc_addr_u addr;
    soc_data_t wdata;
    soc_strb_t strb;
  } soc_req_t;

  typedef struct packed {
    soc_data_t rdata;
    logic      err;
  } soc_rsp_t;

  typedef struct packed {
    logic      we;
    soc_addr_u addr;
    soc_data_t wdata;
    soc_strb_t strb;
  } soc_tgt_req_t;

  typedef struct packed {
    soc_data_t rdata;
    logic      err;
  } soc_tgt_rsp_t;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`SOC_ADDR_W-1:0] paddr;
    logic [31:0]            pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    tgt_l2,
    tgt_uart,
    tgt_ctrl,
    tgt_none
  } soc_target_e;

  // Byte-wise merge under strobes
  function automatic soc_data_t merge_strb(soc_data_t old_d, soc_data_t new_d, soc_strb_t strb);
    soc_data_t res;
    res = old_d;
    for (int b = 0; b < `SOC_DATA_W/8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_d[8*b +: 8];
    end
    return res;
  endfunction

endpackage

/* logic/soc_params.svh */
// Fixed memory map; SOC_L2_LEN must equal SOC_L2_WORDS data words, all regions are size-aligned
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64

// L2 depth in data words
`define SOC_L2_WORDS 1024

// Memory map
`define SOC_L2_BASE   32'h8000_0000
`define SOC_L2_LEN    32'h0000_2000
`define SOC_UART_BASE 32'hC000_0000
`define SOC_UART_LEN  32'h0000_1000
`define SOC_CTRL_BASE 32'hD000_0000
`define SOC_CTRL_LEN  32'h0000_1000

// Control page register offsets
`define SOC_REG_EXIT    12'h000
`define SOC_REG_CNT_EN  12'h008
`define SOC_REG_L2_BASE 12'h010
`define SOC_REG_L2_END  12'h018

`endif
